/* Makefile */
VERILATOR ?= verilator
TOP       ?= bpu_tb
FILELIST  ?= list.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -j 0

FAIL_MSG  := Result: FAILED
SOURCES   := $(shell grep -v '^+' $(FILELIST))
SIM_EXE   := $(BUILD_DIR)/V$(TOP)

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run $(TOP) and search $(LOG) for failure"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   show this list"
	@echo "variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS"

$(SIM_EXE): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

test: $(SIM_EXE)
	@./$(SIM_EXE) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "simulation reported failure, see $(LOG)"; \
		exit 1; \
	fi; \
	if [ $$status -ne 0 ]; then \
		echo "simulator exited with status $$status"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* bench/bpu_tb.sv */
`timescale 1ns/10ps

module bpu_tb;

    import bpu_pkg::*;

    localparam int idx_wid   = 4;
    localparam int hist_len  = 3;
    localparam int tag_lsb   = inst_align_wid + idx_wid;
    localparam int tag_wid   = $bits(addr_t) - tag_lsb;
    localparam int btb_size  = 2 ** idx_wid;
    localparam int pht_size  = 2 ** (idx_wid + hist_len);
    localparam int max_train = 8;

    // worst-case cycles per test with reset counted first.
    localparam int test_cycles = 12 + 20 + 36 + 10 + 15 + 10 + 14;
    localparam int timeout_cycles = 2 * test_cycles;

    logic         clk;
    logic         arst_n;
    logic         stall;
    addr_t        pc;
    btb_invalid_t btb_invalid;
    br_resolved_t resolved;
    btb_predict_t predict;

    // reference model state.
    logic [hist_len-1:0] m_hist;
    sat_ctr_e            m_ctr    [pht_size];
    logic                m_valid  [btb_size];
    logic [tag_wid-1:0]  m_tag    [btb_size];
    addr_t               m_target [btb_size];
    logic                m_hit_q;
    addr_t               m_target_q;
    sat_ctr_e            m_ctr_q;

    int          valid_errs;
    int          npc_errs;
    int          other_errs;
    int          num_checks;
    int          cycle_cnt;
    addr_t       brn_pc;
    addr_t       brn_tgt;

    bpu uut (
        .clk         (clk),
        .arst_n      (arst_n),
        .stall       (stall),
        .pc          (pc),
        .predict     (predict),
        .btb_invalid (btb_invalid),
        .resolved    (resolved)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    initial begin
        cycle_cnt = 0;
        while (cycle_cnt < timeout_cycles) begin
            @(posedge clk);
            cycle_cnt++;
        end
        $display("timeout: no result after %0d clock cycles", cycle_cnt);
        $display("Result: FAILED");
        $finish;
    end

    function automatic logic [idx_wid-1:0] pc_index(input addr_t a);
        return a[inst_align_wid +: idx_wid];
    endfunction

    function automatic logic [tag_wid-1:0] pc_tag(input addr_t a);
        return a[$bits(addr_t)-1:tag_lsb];
    endfunction

    function automatic logic ctr_is_taken(input sat_ctr_e c);
        return (c == weakly_taken) || (c == strongly_taken);
    endfunction

    // one step along the counter order and held at the ends.
    function automatic sat_ctr_e ctr_step(input sat_ctr_e c, input logic taken);
        if (taken && c != strongly_taken) begin
            return sat_ctr_e'(c + 2'd1);
        end
        if (!taken && c != strongly_nottaken) begin
            return sat_ctr_e'(c - 2'd1);
        end
        return c;
    endfunction

    function automatic logic model_predicts_taken();
        return m_hit_q && ctr_is_taken(m_ctr_q);
    endfunction

    function automatic addr_t rand_pc();
        addr_t a;
        a = $urandom;
        a[inst_align_wid-1:0] = '0;
        return a;
    endfunction

    function automatic br_resolved_t make_resolve(input logic v, input addr_t br_pc,
                                                  input logic taken, input addr_t tgt);
        br_resolved_t r;
        r.valid  = v;
        r.pc     = br_pc;
        r.taken  = taken;
        r.target = tgt;
        return r;
    endfunction

    function automatic btb_invalid_t make_invalid(input logic v, input addr_t inv_pc);
        btb_invalid_t r;
        r.valid = v;
        r.pc    = inv_pc;
        return r;
    endfunction

    task automatic check_valid(input string sig, input logic got, input logic want);
        num_checks++;
        if (got !== want) begin
            $display("[FAIL] %s: got 0x%h, expected 0x%h at %0t", sig, got, want, $time);
            valid_errs++;
        end
    endtask

    task automatic check_addr(input string sig, input addr_t got, input addr_t want);
        num_checks++;
        if (got !== want) begin
            $display("[FAIL] %s: got 0x%h, expected 0x%h at %0t", sig, got, want, $time);
            npc_errs++;
        end
    endtask

    task automatic report_error(input string what);
        $display("ERROR: %s at %0t", what, $time);
        other_errs++;
    endtask

    task automatic model_reset();
        m_hist = '0;
        for (int i = 0; i < pht_size; i++) begin
            m_ctr[i] = weakly_nottaken;
        end
        for (int i = 0; i < btb_size; i++) begin
            m_valid[i] = 1'b0;
        end
        m_hit_q    = 1'b0;
        m_target_q = '0;
        m_ctr_q    = weakly_nottaken;
    endtask

    // drives one cycle at the falling edge and checks at the next one.
    task automatic step(input addr_t fetch_pc, input logic stl,
                        input br_resolved_t res, input btb_invalid_t inv);
        logic [idx_wid-1:0]          li;
        logic [idx_wid-1:0]          ri;
        logic [idx_wid-1:0]          ii;
        logic [idx_wid+hist_len-1:0] ci;
        logic                        want_valid;
        pc          = fetch_pc;
        stall       = stl;
        resolved    = res;
        btb_invalid = inv;
        // lookup sees the state before the edge.
        if (!stl) begin
            li         = pc_index(fetch_pc);
            m_hit_q    = m_valid[li] && (m_tag[li] == pc_tag(fetch_pc));
            m_target_q = m_target[li];
            m_ctr_q    = m_ctr[{li, m_hist}];
        end
        ri = pc_index(res.pc);
        ii = pc_index(inv.pc);
        if (inv.valid && m_valid[ii] && (m_tag[ii] == pc_tag(inv.pc)) &&
            !(res.valid && res.taken && (ri == ii))) begin
            m_valid[ii] = 1'b0;
        end
        if (res.valid) begin
            ci        = {ri, m_hist};
            m_ctr[ci] = ctr_step(m_ctr[ci], res.taken);
            m_hist    = {m_hist[hist_len-2:0], res.taken};
            if (res.taken) begin
                m_valid[ri]  = 1'b1;
                m_tag[ri]    = pc_tag(res.pc);
                m_target[ri] = res.target;
            end
        end
        @(posedge clk);
        @(negedge clk);
        want_valid = model_predicts_taken();
        check_valid("predict.valid", predict.valid, want_valid);
        if (want_valid) begin
            check_addr("predict.npc", predict.npc, m_target_q);
        end
    endtask

    task automatic idle(input addr_t fetch_pc, input logic stl);
        step(fetch_pc, stl, make_resolve(1'b0, '0, 1'b0, '0), make_invalid(1'b0, '0));
    endtask

    // taken resolves until the counter at the current history predicts taken.
    task automatic train_branch(input addr_t br_pc, input addr_t tgt, input logic stl);
        int n;
        n = 0;
        do begin
            step(rand_pc(), stl, make_resolve(1'b1, br_pc, 1'b1, tgt),
                 make_invalid(1'b0, '0));
            n++;
        end while (!ctr_is_taken(m_ctr[{pc_index(br_pc), m_hist}]) && n < max_train);
        if (!ctr_is_taken(m_ctr[{pc_index(br_pc), m_hist}])) begin
            report_error("counter did not reach a taken state during training");
        end
    endtask

    task automatic reset_state();
        check_valid("predict.valid", predict.valid, 1'b0);
        for (int i = 0; i < 20; i++) begin
            idle(rand_pc(), 1'b0);
        end
    endtask

    task automatic train_taken();
        for (int i = 0; i < 4; i++) begin
            brn_pc  = rand_pc();
            brn_tgt = rand_pc();
            train_branch(brn_pc, brn_tgt, 1'b0);
            idle(brn_pc, 1'b0);
            check_valid("predict.valid", predict.valid, 1'b1);
            check_addr("predict.npc", predict.npc, brn_tgt);
        end
    endtask

    task automatic walk_down();
        logic prev;
        logic saw_fall;
        idle(brn_pc, 1'b0);
        prev     = predict.valid;
        saw_fall = 1'b0;
        for (int i = 0; i < 8; i++) begin
            step(brn_pc, 1'b0, make_resolve(1'b1, brn_pc, 1'b0, brn_tgt),
                 make_invalid(1'b0, '0));
            if (prev && !predict.valid) begin
                saw_fall = 1'b1;
            end
            prev = predict.valid;
        end
        idle(brn_pc, 1'b0);
        if (!saw_fall) begin
            report_error("prediction never fell during not-taken resolves");
        end
    endtask

    task automatic invalidate();
        addr_t p;
        addr_t t;
        p = rand_pc();
        t = rand_pc();
        train_branch(p, t, 1'b0);
        idle(p, 1'b0);
        // other tag at the same index.
        step(p, 1'b0, make_resolve(1'b0, '0, 1'b0, '0), make_invalid(1'b1, p ^ 32'h0010_0000));
        idle(p, 1'b0);
        // taken resolve and invalidation on one entry.
        step(p, 1'b0, make_resolve(1'b1, p, 1'b1, t), make_invalid(1'b1, p));
        idle(p, 1'b0);
        step(p, 1'b0, make_resolve(1'b0, '0, 1'b0, '0), make_invalid(1'b1, p));
        idle(p, 1'b0);
        check_valid("predict.valid", predict.valid, 1'b0);
    endtask

    task automatic tag_alias();
        brn_pc  = rand_pc();
        brn_tgt = rand_pc();
        train_branch(brn_pc, brn_tgt, 1'b0);
        idle(brn_pc ^ 32'h8000_0000, 1'b0);
        idle(brn_pc, 1'b0);
    endtask

    task automatic stall_hold();
        addr_t q;
        addr_t t;
        idle(brn_pc, 1'b0);
        check_valid("predict.valid", predict.valid, 1'b1);
        for (int i = 0; i < 4; i++) begin
            idle(rand_pc(), 1'b1);
        end
        q = rand_pc();
        t = rand_pc();
        train_branch(q, t, 1'b1);
        idle(q, 1'b0);
        check_valid("predict.valid", predict.valid, 1'b1);
        check_addr("predict.npc", predict.npc, t);
    endtask

    initial begin
        int total_errs;
        void'($urandom(32'ha429_179d));
        valid_errs  = 0;
        npc_errs    = 0;
        other_errs  = 0;
        num_checks  = 0;
        arst_n      = 1'b0;
        stall       = 1'b0;
        pc          = '0;
        btb_invalid = '0;
        resolved    = '0;
        model_reset();
        repeat (10) @(posedge clk);
        @(negedge clk);
        arst_n = 1'b1;

        reset_state();
        train_taken();
        walk_down();
        invalidate();
        tag_alias();
        stall_hold();

        total_errs = valid_errs + npc_errs + other_errs;
        $display("%0d checks: %0d valid errors, %0d npc errors, %0d other errors",
                 num_checks, valid_errs, npc_errs, other_errs);
        if (total_errs == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

/* list.f */
src/bpu_pkg.sv
src/pht_ram.sv
src/btb.sv
src/bpu.sv
bench/bpu_tb.sv

/* src/bpu.sv */
`timescale 1ns/10ps

module bpu #(
    parameter int btb_idx_wid = 4,
    parameter int history_len = 3
) (
    input  logic                  clk,
    input  logic                  arst_n,

    // fetch stage 1.
    input  logic                  stall,
    input  bpu_pkg::addr_t        pc,
    output bpu_pkg::btb_predict_t predict,

    // fetch stage 2.
    input  bpu_pkg::btb_invalid_t btb_invalid,

    // execute.
    input  bpu_pkg::br_resolved_t resolved
);

    import bpu_pkg::*;

    localparam int pht_idx_wid = btb_idx_wid + history_len;

    typedef logic [history_len-1:0] history_t;
    typedef logic [btb_idx_wid-1:0] pc_idx_t;
    typedef logic [pht_idx_wid-1:0] pht_idx_t;

    // global history, newest outcome in bit 0.
    history_t                 history;
    logic [history_len:0]     history_shift;

    // counter table connections.
    pc_idx_t  res_pc_idx;
    pc_idx_t  fetch_pc_idx;
    logic     upd_wen;
    pht_idx_t upd_idx;
    sat_ctr_e upd_data;
    sat_ctr_e upd_rd_data;
    pht_idx_t lookup_idx;
    sat_ctr_e lookup_data;
    sat_ctr_e lookup_hold;
    logic     hold_taken;

    // btb results.
    addr_t    target_pc;
    logic     target_hit;

    assign history_shift = {history, resolved.taken};

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            history <= '0;
        end else if (resolved.valid) begin
            history <= history_shift[history_len-1:0];
        end
    end

    assign res_pc_idx   = resolved.pc[inst_align_wid +: btb_idx_wid];
    assign fetch_pc_idx = pc[inst_align_wid +: btb_idx_wid];

    // both ports index with the history before this edge.
    assign upd_wen    = resolved.valid;
    assign upd_idx    = {res_pc_idx, history};
    assign lookup_idx = {fetch_pc_idx, history};

    // one step toward the outcome, saturating at both ends.
    always_comb begin
        upd_data = upd_rd_data;
        case (upd_rd_data)
            strongly_nottaken: begin
                upd_data = resolved.taken ? weakly_nottaken : strongly_nottaken;
            end
            weakly_nottaken: begin
                upd_data = resolved.taken ? weakly_taken : strongly_nottaken;
            end
            weakly_taken: begin
                upd_data = resolved.taken ? strongly_taken : weakly_nottaken;
            end
            strongly_taken: begin
                upd_data = resolved.taken ? strongly_taken : weakly_taken;
            end
            default: begin
                upd_data = weakly_nottaken;
            end
        endcase
    end

    pht_ram #(
        .addr_wid    (pht_idx_wid)
    ) u_pht_ram (
        .clk         (clk),
        .arst_n      (arst_n),
        .upd_wen     (upd_wen),
        .upd_idx     (upd_idx),
        .upd_data    (upd_data),
        .upd_rd_data (upd_rd_data),
        .lookup_idx  (lookup_idx),
        .lookup_data (lookup_data)
    );

    btb #(
        .btb_idx_wid (btb_idx_wid)
    ) u_btb (
        .clk         (clk),
        .arst_n      (arst_n),
        .stall       (stall),
        .pc          (pc),
        .btb_invalid (btb_invalid),
        .resolved    (resolved),
        .target_pc   (target_pc),
        .target_hit  (target_hit)
    );

    // lines up the counter with the registered btb lookup.
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            lookup_hold <= weakly_nottaken;
        end else if (!stall) begin
            lookup_hold <= lookup_data;
        end
    end

    assign hold_taken = (lookup_hold == weakly_taken) || (lookup_hold == strongly_taken);

    // predict taken only on a btb hit with a taken counter.
    assign predict.valid = target_hit && hold_taken;
    assign predict.npc   = target_pc;

endmodule

/* src/bpu_pkg.sv */
package bpu_pkg;

    // instruction address as seen by fetch and execute.
    typedef logic [31:0] addr_t;

    // instructions are word aligned, so the low pc bits carry no index.
    localparam int inst_align_wid = 2;

    // two-bit saturating direction counter.
    typedef enum logic [1:0] {
        strongly_nottaken = 2'b00,
        weakly_nottaken   = 2'b01,
        weakly_taken      = 2'b10,
        strongly_taken    = 2'b11
    } sat_ctr_e;

    // prediction toward fetch stage 1.
    typedef struct packed {
        logic  valid;
        addr_t npc;
    } btb_predict_t;

    // fetch stage 2 found no branch at this pc.
    typedef struct packed {
        logic  valid;
        addr_t pc;
    } btb_invalid_t;

    // branch outcome from execute.
    typedef struct packed {
        logic  valid;
        addr_t pc;
        logic  taken;
        addr_t target;
    } br_resolved_t;

endpackage

/* src/btb.sv */
`timescale 1ns/10ps

module btb #(
    parameter int btb_idx_wid = 4
) (
    input  logic                  clk,
    input  logic                  arst_n,

    // fetch stage 1 lookup.
    input  logic                  stall,
    input  bpu_pkg::addr_t        pc,

    // fetch stage 2 invalidation.
    input  bpu_pkg::btb_invalid_t btb_invalid,

    // training from execute.
    input  bpu_pkg::br_resolved_t resolved,

    output bpu_pkg::addr_t        target_pc,
    output logic                  target_hit
);

    import bpu_pkg::*;

    localparam int btb_size = 2 ** btb_idx_wid;
    localparam int tag_wid  = $bits(addr_t) - btb_idx_wid - inst_align_wid;

    typedef logic [btb_idx_wid-1:0] btb_idx_t;
    typedef logic [tag_wid-1:0]     btb_tag_t;

    // index sits just above the alignment bits.
    function automatic btb_idx_t get_idx(input addr_t addr);
        return addr[inst_align_wid +: btb_idx_wid];
    endfunction

    // tag is everything above the index.
    function automatic btb_tag_t get_tag(input addr_t addr);
        return addr[$bits(addr_t)-1 -: tag_wid];
    endfunction

    // entry storage.
    logic [btb_size-1:0] entry_valid;
    btb_tag_t            tag_mem    [btb_size];
    addr_t               target_mem [btb_size];

    // lookup side.
    btb_idx_t lkp_idx;
    btb_tag_t lkp_tag;
    logic     lkp_hit;
    addr_t    lkp_target;

    // training side.
    btb_idx_t train_idx;
    btb_tag_t train_tag;
    logic     train_en;

    // invalidation side.
    btb_idx_t inv_idx;
    btb_tag_t inv_tag;
    logic     inv_match;
    logic     inv_en;

    assign lkp_idx = get_idx(pc);
    assign lkp_tag = get_tag(pc);

    // reads see the state before this edge, no forwarding.
    assign lkp_hit    = entry_valid[lkp_idx] && (tag_mem[lkp_idx] == lkp_tag);
    assign lkp_target = target_mem[lkp_idx];

    // only taken branches allocate or refresh an entry.
    assign train_idx = get_idx(resolved.pc);
    assign train_tag = get_tag(resolved.pc);
    assign train_en  = resolved.valid && resolved.taken;

    assign inv_idx   = get_idx(btb_invalid.pc);
    assign inv_tag   = get_tag(btb_invalid.pc);
    assign inv_match = entry_valid[inv_idx] && (tag_mem[inv_idx] == inv_tag);

    // a taken resolve to the same slot wins over the invalidation.
    assign inv_en = btb_invalid.valid && inv_match &&
                    !(train_en && (train_idx == inv_idx));

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            entry_valid <= '0;
        end else begin
            if (inv_en) begin
                entry_valid[inv_idx] <= 1'b0;
            end
            if (train_en) begin
                entry_valid[train_idx] <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (train_en) begin
            tag_mem[train_idx]    <= train_tag;
            target_mem[train_idx] <= resolved.target;
        end
    end

    // registered lookup result, held while fetch is stalled.
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            target_hit <= 1'b0;
        end else if (!stall) begin
            target_hit <= lkp_hit;
        end
    end

    // target is payload only, qualified by target_hit.
    always_ff @(posedge clk) begin
        if (!stall) begin
            target_pc <= lkp_target;
        end
    end

endmodule

/* src/pht_ram.sv */
`timescale 1ns/10ps

module pht_ram #(
    parameter int addr_wid = 7
) (
    input  logic                  clk,
    input  logic                  arst_n,

    // read-modify-write port used by training.
    input  logic                  upd_wen,
    input  logic [addr_wid-1:0]   upd_idx,
    input  bpu_pkg::sat_ctr_e     upd_data,
    output bpu_pkg::sat_ctr_e     upd_rd_data,

    // lookup port used by fetch.
    input  logic [addr_wid-1:0]   lookup_idx,
    output bpu_pkg::sat_ctr_e     lookup_data
);

    import bpu_pkg::*;

    localparam int depth = 2 ** addr_wid;

    sat_ctr_e ctr_mem [depth];

    // every counter starts weakly not taken.
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < depth; i++) begin
                ctr_mem[i] <= weakly_nottaken;
            end
        end else if (upd_wen) begin
            ctr_mem[upd_idx] <= upd_data;
        end
    end

    // both reads are combinational.
    assign upd_rd_data = ctr_mem[upd_idx];
    assign lookup_data = ctr_mem[lookup_idx];

endmodule
